// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = radio_ctrl_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/apb_cmd_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_cmd_port import radio_ctrl_pkg::*; (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         psel_i,
  input  wire         penable_i,
  input  wire         pwrite_i,
  input  wire  [3:0]  paddr_i,
  input  wire  [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  ctrl_bus_if.issuer  bus
);

  logic        access;
  logic        addr_ok;
  logic        dir_ok;
  logic        wr_data;
  logic        wr_issue;
  logic        rd_resp_hi;
  logic [31:0] data_q;   // Staged command data

  assign access = psel_i & penable_i;

  always_comb begin
    addr_ok = 1'b1;
    dir_ok  = 1'b0;
    case (paddr_i)
      REG_CMD_DATA, REG_CMD_ISSUE: dir_ok = pwrite_i;
      REG_RESP_LO, REG_RESP_HI:    dir_ok = !pwrite_i;
      default:                     addr_ok = 1'b0;
    endcase
  end

  assign wr_data    = access & dir_ok & (paddr_i == REG_CMD_DATA);
  assign wr_issue   = access & dir_ok & (paddr_i == REG_CMD_ISSUE);
  assign rd_resp_hi = access & dir_ok & (paddr_i == REG_RESP_HI);

  assign pready_o  = 1'b1;                       // No wait states
  assign pslverr_o = access & !(addr_ok & dir_ok);

  always_comb begin
    case (paddr_i)
      REG_RESP_LO: prdata_o = bus.resp[31:0];
      REG_RESP_HI: prdata_o = {24'h000000, bus.resp[39:32]};
      default:     prdata_o = 32'h0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bus.cmd_valid <= 1'b0;
      bus.resp_rqst <= 1'b0;
      data_q        <= 32'h0;
    end else begin
      bus.cmd_valid <= wr_issue;
      bus.resp_rqst <= rd_resp_hi;   // Next word is built after the read
      if (wr_data)
        data_q <= pwdata_i;
    end
  end

  // Address and flags of the command being issued
  always_ff @(posedge clk) begin
    if (wr_issue) begin
      bus.cmd_addr <= pwdata_i[5:0];
      bus.cmd_resp <= pwdata_i[6];
      bus.cmd_ptt  <= pwdata_i[7];
    end
  end

  assign bus.cmd_data = data_q;

  a_penable_needs_psel : assert property (
    @(posedge clk) disable iff (!rst_n_i) penable_i |-> psel_i
  );

endmodule

`default_nettype wire

// File: hw/ctrl_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_bus_if import radio_ctrl_pkg::*; ();
  logic        cmd_valid;   // One-cycle command strobe
  logic [5:0]  cmd_addr;
  logic [31:0] cmd_data;
  logic        cmd_resp;    // Command wants an echo
  logic        cmd_ptt;
  logic        resp_rqst;   // Host has taken the current word
  resp_word_u  resp;

  modport issuer (
    output cmd_valid, cmd_addr, cmd_data, cmd_resp, cmd_ptt, resp_rqst,
    input  resp
  );

  modport cfg_sink (
    input cmd_valid, cmd_addr, cmd_data, cmd_ptt
  );

  modport responder (
    input  cmd_valid, cmd_addr, cmd_data, cmd_resp, resp_rqst,
    output resp
  );
endinterface

`default_nettype wire

// File: hw/led_flash.sv
`timescale 1ns/1ps
`default_nettype none

module led_flash import radio_ctrl_pkg::*; (
  input  wire  clk,
  input  wire  rst_n_i,
  input  wire  tick_i,
  input  wire  sig_i,
  output logic led_n_o
);

  logic [1:0] state;
  logic [1:0] state_next;

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      state <= LED_CLR;
    else
      state <= state_next;
  end

  // Holds the LED on for 2 to 3 ticks
  always_comb begin
    state_next = state;
    case (state)
      LED_CLR:   if (sig_i)  state_next = LED_SET;
      LED_SET:   if (tick_i) state_next = LED_WAIT1;
      LED_WAIT1: if (tick_i) state_next = LED_WAIT2;
      LED_WAIT2: if (tick_i) state_next = LED_CLR;
      default:   state_next = LED_CLR;
    endcase
  end

  assign led_n_o = (state == LED_CLR);   // Active low

  a_clr_needs_sig : assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (state == LED_CLR && !sig_i) |=> (state == LED_CLR)
  );

endmodule

`default_nettype wire

// File: hw/radio_ctrl_pkg.sv
`default_nettype none

package radio_ctrl_pkg;

  localparam int MS_CYCLES   = 2500;                // clk runs at 2.5 MHz
  localparam int MS_CNT_W    = $clog2(MS_CYCLES);
  localparam int LED_TICK_MS = 64;
  localparam int LED_CNT_W   = $clog2(LED_TICK_MS);
  localparam int CW_DELAY_MS = 17;                  // Delay line stages

  // Minimum hang after key up to cover the delay line and envelope decay
  localparam logic [9:0] KEY_UP_TIMEOUT = 10'd41;
  localparam logic [7:0] SERIAL_NO      = 8'h2a;

  // Command addresses and the TX_CFG bit positions
  localparam logic [5:0] CMD_ADDR_TX_CFG  = 6'h09;
  localparam logic [5:0] CMD_ADDR_CW_HANG = 6'h10;
  localparam int         TX_CFG_VNA_BIT   = 23;
  localparam int         TX_CFG_PA_EN_BIT = 19;
  localparam int         TX_CFG_TR_DIS_BIT = 18;

  // APB register offsets
  localparam logic [3:0] REG_CMD_DATA  = 4'h0;
  localparam logic [3:0] REG_CMD_ISSUE = 4'h4;
  localparam logic [3:0] REG_RESP_LO   = 4'h8;
  localparam logic [3:0] REG_RESP_HI   = 4'hc;

  // LED stretcher states
  localparam logic [1:0] LED_CLR   = 2'b00;
  localparam logic [1:0] LED_SET   = 2'b01;
  localparam logic [1:0] LED_WAIT1 = 2'b10;
  localparam logic [1:0] LED_WAIT2 = 2'b11;

  // Response FSM states
  localparam logic RESP_START = 1'b0;
  localparam logic RESP_WAIT  = 1'b1;

  localparam logic [6:0]  SLOT0_TAG  = 7'b0001111;
  // Slot 0 telemetry, no clip, keys up
  localparam logic [39:0] RESP_RESET = {8'h00, SLOT0_TAG, 1'b0, 16'h0000, SERIAL_NO};

  typedef union packed {
    struct packed {
      logic        flag;     // Always 1 for an echo
      logic [5:0]  addr;
      logic        tx_on;
      logic [31:0] data;
    } echo;
    struct packed {
      logic [2:0]  pad_hi;
      logic [1:0]  slot;
      logic        pad_lo;
      logic        cw_key;
      logic        ptt;
      logic [31:0] payload;
    } tlm;
  } resp_word_u;

endpackage

`default_nettype wire

// File: hw/radio_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_top (
  input  wire         clk,
  input  wire         rst_n_i,
  input  wire         psel_i,
  input  wire         penable_i,
  input  wire         pwrite_i,
  input  wire  [3:0]  paddr_i,
  input  wire  [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  input  wire         run_i,
  input  wire         rx_clip_i,
  input  wire         rx_good_lvl_i,
  input  wire         cw_key_n_i,
  input  wire         ptt_n_i,
  input  wire         tx_inhibit_n_i,
  input  wire  [11:0] fwd_pwr_i,
  input  wire  [11:0] rev_pwr_i,
  input  wire  [11:0] temperature_i,
  input  wire  [11:0] bias_current_i,
  output logic        tx_on_o,
  output logic        pa_tr_o,
  output logic        pa_en_o,
  output logic        pwr_envpa_o,
  output logic        rfsw_sel_o,
  output logic        led_run_n_o,
  output logic        led_tx_n_o,
  output logic        led_good_n_o,
  output logic        led_clip_n_o
);

  logic ms_pulse;
  logic led_tick;
  logic tx_on;
  logic cw_key;   // Synchronized key, reported in telemetry
  logic ptt;

  ctrl_bus_if u_bus ();

  apb_cmd_port u_apb_cmd_port (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .bus       (u_bus.issuer)
  );

  tick_gen u_tick_gen (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ms_pulse_o (ms_pulse),
    .led_tick_o (led_tick)
  );

  tx_sequencer u_tx_sequencer (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .ms_pulse_i     (ms_pulse),
    .run_i          (run_i),
    .cw_key_n_i     (cw_key_n_i),
    .ptt_n_i        (ptt_n_i),
    .tx_inhibit_n_i (tx_inhibit_n_i),
    .bus            (u_bus.cfg_sink),
    .tx_on_o        (tx_on),
    .cw_key_o       (cw_key),
    .ptt_o          (ptt),
    .pa_tr_o        (pa_tr_o),
    .pa_en_o        (pa_en_o),
    .pwr_envpa_o    (pwr_envpa_o),
    .rfsw_sel_o     (rfsw_sel_o)
  );

  resp_builder u_resp_builder (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .rx_clip_i      (rx_clip_i),
    .tx_on_i        (tx_on),
    .cw_key_i       (cw_key),
    .ptt_i          (ptt),
    .fwd_pwr_i      (fwd_pwr_i),
    .rev_pwr_i      (rev_pwr_i),
    .temperature_i  (temperature_i),
    .bias_current_i (bias_current_i),
    .bus            (u_bus.responder)
  );

  assign tx_on_o = tx_on;

  // Status LEDs
  led_flash u_led_run (
    .clk(clk), .rst_n_i(rst_n_i), .tick_i(led_tick), .sig_i(run_i), .led_n_o(led_run_n_o)
  );

  led_flash u_led_tx (
    .clk(clk), .rst_n_i(rst_n_i), .tick_i(led_tick), .sig_i(tx_on), .led_n_o(led_tx_n_o)
  );

  led_flash u_led_good (
    .clk(clk), .rst_n_i(rst_n_i), .tick_i(led_tick), .sig_i(rx_good_lvl_i),
    .led_n_o(led_good_n_o)
  );

  led_flash u_led_clip (
    .clk(clk), .rst_n_i(rst_n_i), .tick_i(led_tick), .sig_i(rx_clip_i),
    .led_n_o(led_clip_n_o)
  );

endmodule

`default_nettype wire

// File: hw/resp_builder.sv
`timescale 1ns/1ps
`default_nettype none

module resp_builder import radio_ctrl_pkg::*; (
  input  wire           clk,
  input  wire           rst_n_i,
  input  wire           rx_clip_i,
  input  wire           tx_on_i,
  input  wire           cw_key_i,
  input  wire           ptt_i,
  input  wire  [11:0]   fwd_pwr_i,
  input  wire  [11:0]   rev_pwr_i,
  input  wire  [11:0]   temperature_i,
  input  wire  [11:0]   bias_current_i,
  ctrl_bus_if.responder bus
);

  logic        state;       // RESP_WAIT while an echo is pending
  logic        capture;
  logic [5:0]  pend_addr;
  logic [31:0] pend_data;
  logic [1:0]  slot;
  logic [1:0]  clip_cnt;
  resp_word_u  echo_word;
  resp_word_u  tlm_word;

  // A new command is only taken once the old echo goes out
  assign capture = bus.cmd_valid & bus.cmd_resp & ((state == RESP_START) | bus.resp_rqst);

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      state <= RESP_START;
    else if (capture)
      state <= RESP_WAIT;
    else if (bus.resp_rqst)
      state <= RESP_START;
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      pend_addr <= bus.cmd_addr;
      pend_data <= bus.cmd_data;
    end
  end

  always_comb begin
    echo_word.echo.flag  = 1'b1;
    echo_word.echo.addr  = pend_addr;
    echo_word.echo.tx_on = tx_on_i;
    echo_word.echo.data  = pend_data;

    tlm_word            = '0;
    tlm_word.tlm.slot   = slot;
    tlm_word.tlm.cw_key = cw_key_i;
    tlm_word.tlm.ptt    = ptt_i;
    case (slot)
      2'd0:    tlm_word.tlm.payload = {SLOT0_TAG, &clip_cnt, 16'h0000, SERIAL_NO};
      2'd1:    tlm_word.tlm.payload = {4'h0, temperature_i, 4'h0, fwd_pwr_i};
      2'd2:    tlm_word.tlm.payload = {4'h0, rev_pwr_i, 4'h0, bias_current_i};
      default: tlm_word.tlm.payload = 32'h0;   // Spare slot
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      bus.resp <= RESP_RESET;
      slot     <= 2'd1;       // Reset word already stands in for slot 0
      clip_cnt <= 2'd0;
    end else if (bus.resp_rqst) begin
      bus.resp <= (state == RESP_WAIT) ? echo_word : tlm_word;
      slot     <= slot + 2'd1;   // Skipped when an echo goes out
      clip_cnt <= 2'd0;
    end else if (!(&clip_cnt)) begin
      clip_cnt <= clip_cnt + {1'b0, rx_clip_i};
    end
  end

endmodule

`default_nettype wire

// File: hw/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen import radio_ctrl_pkg::*; (
  input  wire  clk,
  input  wire  rst_n_i,
  output logic ms_pulse_o,
  output logic led_tick_o
);

  logic [MS_CNT_W-1:0]  div_cnt;
  logic [LED_CNT_W-1:0] ms_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      div_cnt    <= '0;
      ms_pulse_o <= 1'b0;
    end else if (div_cnt == MS_CNT_W'(MS_CYCLES - 1)) begin
      div_cnt    <= '0;
      ms_pulse_o <= 1'b1;
    end else begin
      div_cnt    <= div_cnt + 1'b1;
      ms_pulse_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i)
      ms_cnt <= '0;
    else if (ms_pulse_o)
      ms_cnt <= ms_cnt + 1'b1;   // Wraps every LED tick
  end

  assign led_tick_o = ms_pulse_o & (&ms_cnt);

endmodule

`default_nettype wire

// File: hw/tx_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_sequencer import radio_ctrl_pkg::*; (
  input  wire          clk,
  input  wire          rst_n_i,
  input  wire          ms_pulse_i,
  input  wire          run_i,
  input  wire          cw_key_n_i,
  input  wire          ptt_n_i,
  input  wire          tx_inhibit_n_i,
  ctrl_bus_if.cfg_sink bus,
  output logic         tx_on_o,
  output logic         cw_key_o,
  output logic         ptt_o,
  output logic         pa_tr_o,
  output logic         pa_en_o,
  output logic         pwr_envpa_o,
  output logic         rfsw_sel_o
);

  logic                   vna;
  logic                   pa_enable;
  logic                   tr_disable;
  logic                   int_ptt;      // ptt flag of the last command
  logic [9:0]             hang_time;
  logic [2:0]             sync1;
  logic [2:0]             sync2;
  logic                   ext_cwkey;
  logic                   ext_ptt;
  logic                   ext_inhibit;
  logic [CW_DELAY_MS-1:0] delay_line;
  logic                   cw_keydown;
  logic [9:0]             timeout;
  logic                   hang_phase;   // Second count runs the hang time
  logic                   cw_power_on;
  logic                   power_on;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      vna        <= 1'b0;
      pa_enable  <= 1'b0;
      tr_disable <= 1'b0;
      int_ptt    <= 1'b0;
      hang_time  <= 10'd0;
    end else if (bus.cmd_valid) begin
      int_ptt <= bus.cmd_ptt;
      if (bus.cmd_addr == CMD_ADDR_TX_CFG) begin
        vna        <= bus.cmd_data[TX_CFG_VNA_BIT];
        pa_enable  <= bus.cmd_data[TX_CFG_PA_EN_BIT];
        tr_disable <= bus.cmd_data[TX_CFG_TR_DIS_BIT];
      end else if (bus.cmd_addr == CMD_ADDR_CW_HANG) begin
        hang_time <= {bus.cmd_data[31:24], bus.cmd_data[17:16]};
      end
    end
  end

  // Two-flop synchronizers, idle high
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      sync1 <= 3'b111;
      sync2 <= 3'b111;
    end else begin
      sync1 <= {cw_key_n_i, ptt_n_i, tx_inhibit_n_i};
      sync2 <= sync1;
    end
  end

  assign {ext_cwkey, ext_ptt, ext_inhibit} = ~sync2;

  assign tx_on_o = (int_ptt | cw_keydown | ext_ptt) & ~ext_inhibit & run_i;

  // Key is delayed one ms per stage so relays settle first
  always_ff @(posedge clk) begin
    if (!rst_n_i)
      delay_line <= '0;
    else if (ms_pulse_i)
      delay_line <= {delay_line[CW_DELAY_MS-2:0], ext_cwkey};
  end

  assign cw_keydown = delay_line[CW_DELAY_MS-1];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      timeout     <= 10'd0;
      hang_phase  <= 1'b0;
      cw_power_on <= 1'b0;
    end else if (ext_cwkey) begin       // Restart on every key down
      timeout     <= KEY_UP_TIMEOUT;
      hang_phase  <= 1'b0;
      cw_power_on <= 1'b1;
    end else if (ms_pulse_i) begin
      if (timeout != 10'd0) begin
        timeout <= timeout - 10'd1;
      end else if (!hang_phase && hang_time != 10'd0) begin
        timeout    <= hang_time - 10'd1;   // Load step counts as one ms
        hang_phase <= 1'b1;
      end else begin
        cw_power_on <= 1'b0;
      end
    end
  end

  assign power_on = cw_power_on | tx_on_o;

  assign pa_tr_o     = power_on & ~vna & (pa_enable | ~tr_disable);
  assign pa_en_o     = power_on & ~vna & pa_enable;
  assign pwr_envpa_o = power_on;
  assign rfsw_sel_o  = ~vna & pa_enable;
  assign cw_key_o    = ext_cwkey;
  assign ptt_o       = ext_ptt;

  a_pa_en_with_tr : assert property (
    @(posedge clk) disable iff (!rst_n_i) pa_en_o |-> pa_tr_o
  );

endmodule

`default_nettype wire

// File: sources.f
hw/radio_ctrl_pkg.sv
hw/ctrl_bus_if.sv
hw/apb_cmd_port.sv
hw/tick_gen.sv
hw/led_flash.sv
hw/tx_sequencer.sv
hw/resp_builder.sv
hw/radio_ctrl_top.sv
tests/radio_ctrl_tb.sv

// File: tests/radio_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module radio_ctrl_tb import radio_ctrl_pkg::*; ();

  localparam int MAX_STEPS = 128;
  // Step operations
  localparam int OP_WR    = 0;
  localparam int OP_RD    = 1;
  localparam int OP_RESP  = 2;   // RESP_LO then RESP_HI, compared as one word
  localparam int OP_PIN   = 3;
  localparam int OP_PULSE = 4;
  localparam int OP_WAIT  = 5;   // data holds milliseconds
  localparam int OP_CHK   = 6;
  // Pins the table can drive
  localparam int PIN_RUN       = 0;
  localparam int PIN_CLIP      = 1;
  localparam int PIN_KEY_N     = 2;
  localparam int PIN_INHIBIT_N = 3;
  localparam int PIN_GOOD      = 4;
  // Outputs the table can check
  localparam int SIG_TX_ON    = 0;
  localparam int SIG_PA_TR    = 1;
  localparam int SIG_PA_EN    = 2;
  localparam int SIG_ENVPA    = 3;
  localparam int SIG_RFSW     = 4;
  localparam int SIG_LED_RUN  = 5;
  localparam int SIG_LED_TX   = 6;
  localparam int SIG_LED_GOOD = 7;
  localparam int SIG_LED_CLIP = 8;

  logic        clk;
  logic        rst_n;
  logic        psel, penable, pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready, pslverr;
  logic        run, rx_clip, rx_good_lvl, cw_key_n, ptt_n, tx_inhibit_n;
  logic [11:0] fwd_pwr, rev_pwr, temperature, bias_current;
  logic        tx_on, pa_tr, pa_en, pwr_envpa, rfsw_sel;
  logic        led_run_n, led_tx_n, led_good_n, led_clip_n;

  string       step_name [MAX_STEPS];
  int          step_op   [MAX_STEPS];
  int          step_sel  [MAX_STEPS];
  logic [31:0] step_data [MAX_STEPS];
  logic        step_bit  [MAX_STEPS];
  resp_word_u  step_word [MAX_STEPS];
  int          n_steps = 0;
  int unsigned cycle_limit = 0;
  int unsigned cycle_cnt = 0;

  radio_ctrl_top u_radio_ctrl_top (
    .clk(clk), .rst_n_i(rst_n),
    .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite), .paddr_i(paddr),
    .pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr),
    .run_i(run), .rx_clip_i(rx_clip), .rx_good_lvl_i(rx_good_lvl),
    .cw_key_n_i(cw_key_n), .ptt_n_i(ptt_n), .tx_inhibit_n_i(tx_inhibit_n),
    .fwd_pwr_i(fwd_pwr), .rev_pwr_i(rev_pwr), .temperature_i(temperature),
    .bias_current_i(bias_current),
    .tx_on_o(tx_on), .pa_tr_o(pa_tr), .pa_en_o(pa_en), .pwr_envpa_o(pwr_envpa),
    .rfsw_sel_o(rfsw_sel), .led_run_n_o(led_run_n), .led_tx_n_o(led_tx_n),
    .led_good_n_o(led_good_n), .led_clip_n_o(led_clip_n)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run went past %0d clock cycles", cycle_limit);
      $display("*** FAILED ***");
      $fatal(1);
    end
  end

  // Telemetry payload per slot, from the response format
  function automatic logic [31:0] slot_payload(input logic [1:0] slot, input logic clip);
    case (slot)
      2'd0:    return {7'b0001111, clip, 16'h0000, SERIAL_NO};
      2'd1:    return {4'h0, temperature, 4'h0, fwd_pwr};
      2'd2:    return {4'h0, rev_pwr, 4'h0, bias_current};
      default: return 32'h0;
    endcase
  endfunction

  function automatic resp_word_u expect_tlm(input logic [1:0] slot, input logic [31:0] payload);
    resp_word_u w;
    w             = '0;   // Keys up
    w.tlm.slot    = slot;
    w.tlm.payload = payload;
    return w;
  endfunction

  function automatic resp_word_u expect_echo(input logic [5:0] addr, input logic txo,
                                             input logic [31:0] data);
    resp_word_u w;
    w.echo.flag  = 1'b1;
    w.echo.addr  = addr;
    w.echo.tx_on = txo;
    w.echo.data  = data;
    return w;
  endfunction

  task automatic add_step(input string name, input int op, input int sel = 0,
                          input logic [31:0] data = 32'h0, input logic bit_v = 1'b0,
                          input resp_word_u word = '0);
    if (n_steps == MAX_STEPS) begin
      $display("Stimulus table is full at step %s", name);
      $display("*** FAILED ***");
      $fatal(1);
    end
    step_name[n_steps] = name;
    step_op[n_steps]   = op;
    step_sel[n_steps]  = sel;
    step_data[n_steps] = data;
    step_bit[n_steps]  = bit_v;
    step_word[n_steps] = word;
    n_steps++;
  endtask

  // Setup and access phase; pready is tied high so one access cycle ends it
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err, output logic rdy);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    @(posedge clk);
    @(negedge clk);
    rdata   = prdata;
    err     = pslverr;
    rdy     = pready;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic set_pin(input int pin, input logic val);
    case (pin)
      PIN_RUN:   run = val;
      PIN_CLIP:  rx_clip = val;
      PIN_KEY_N: cw_key_n = val;
      PIN_GOOD:  rx_good_lvl = val;
      default:   tx_inhibit_n = val;
    endcase
  endtask

  function automatic logic pick_output(input int sel);
    case (sel)
      SIG_TX_ON:    return tx_on;
      SIG_PA_TR:    return pa_tr;
      SIG_PA_EN:    return pa_en;
      SIG_ENVPA:    return pwr_envpa;
      SIG_RFSW:     return rfsw_sel;
      SIG_LED_TX:   return led_tx_n;
      SIG_LED_GOOD: return led_good_n;
      SIG_LED_CLIP: return led_clip_n;
      default:      return led_run_n;
    endcase
  endfunction

  task automatic compare_resp(input string name, input resp_word_u exp, input resp_word_u act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %010h, actual %010h", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_output(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic check_slverr(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected pslverr %b, actual %b", name, exp, act);
      $display("*** FAILED ***");
      $fatal(1);
    end
  endtask

  task automatic build_table();
    add_step("reset_led_run", OP_CHK, SIG_LED_RUN, 32'h0, 1'b1);
    add_step("reset_led_tx", OP_CHK, SIG_LED_TX, 32'h0, 1'b1);
    add_step("reset_led_good", OP_CHK, SIG_LED_GOOD, 32'h0, 1'b1);
    add_step("reset_led_clip", OP_CHK, SIG_LED_CLIP, 32'h0, 1'b1);
    add_step("reset_tx_on", OP_CHK, SIG_TX_ON, 32'h0, 1'b0);
    add_step("reset_envpa", OP_CHK, SIG_ENVPA, 32'h0, 1'b0);
    // Slot rotation after reset
    add_step("resp_reset", OP_RESP, 0, 32'h0, 1'b0, expect_tlm(2'd0, slot_payload(2'd0, 1'b0)));
    add_step("resp_slot1", OP_RESP, 0, 32'h0, 1'b0, expect_tlm(2'd1, slot_payload(2'd1, 1'b0)));
    add_step("resp_slot2", OP_RESP, 0, 32'h0, 1'b0, expect_tlm(2'd2, slot_payload(2'd2, 1'b0)));
    repeat (3) add_step("clip_pulse", OP_PULSE, PIN_CLIP);
    add_step("led_clip_on", OP_CHK, SIG_LED_CLIP, 32'h0, 1'b0);
    add_step("resp_slot3", OP_RESP, 0, 32'h0, 1'b0, expect_tlm(2'd3, 32'h0));
    add_step("resp_slot0_clip", OP_RESP, 0, 32'h0, 1'b0,
             expect_tlm(2'd0, slot_payload(2'd0, 1'b1)));
    add_step("resp_slot1_again", OP_RESP, 0, 32'h0, 1'b0,
             expect_tlm(2'd1, slot_payload(2'd1, 1'b0)));
    // Bad accesses leave the rotation alone
    add_step("wr_resp_lo", OP_WR, 'h8, 32'hffff_ffff, 1'b1);
    add_step("wr_resp_hi", OP_WR, 'hc, 32'hffff_ffff, 1'b1);
    add_step("rd_cmd_data", OP_RD, 'h0, 32'h0, 1'b1);
    add_step("rd_cmd_issue", OP_RD, 'h4, 32'h0, 1'b1);
    add_step("wr_unmapped", OP_WR, 'h2, 32'h0000_00c9, 1'b1);
    add_step("rd_unmapped", OP_RD, 'he, 32'h0, 1'b1);
    add_step("resp_after_errors", OP_RESP, 0, 32'h0, 1'b0,
             expect_tlm(2'd2, slot_payload(2'd2, 1'b0)));
    // Echo of a command that wants a response
    add_step("cmd_data", OP_WR, 'h0, 32'h1234_5678, 1'b0);
    add_step("cmd_issue_resp", OP_WR, 'h4, 32'h0000_0061, 1'b0);
    add_step("resp_before_echo", OP_RESP, 0, 32'h0, 1'b0, expect_tlm(2'd3, 32'h0));
    add_step("resp_echo", OP_RESP, 0, 32'h0, 1'b0, expect_echo(6'h21, 1'b0, 32'h1234_5678));
    add_step("resp_slot_skip", OP_RESP, 0, 32'h0, 1'b0,
             expect_tlm(2'd1, slot_payload(2'd1, 1'b0)));
    // Run and good level LED stretch with ticks 64 ms apart
    add_step("led_run_idle", OP_CHK, SIG_LED_RUN, 32'h0, 1'b1);
    add_step("run_pulse", OP_PULSE, PIN_RUN);
    add_step("good_pulse", OP_PULSE, PIN_GOOD);
    add_step("led_run_on", OP_CHK, SIG_LED_RUN, 32'h0, 1'b0);
    add_step("led_good_on", OP_CHK, SIG_LED_GOOD, 32'h0, 1'b0);
    add_step("led_wait_2ticks", OP_WAIT, 0, 32'd127);
    add_step("led_run_hold", OP_CHK, SIG_LED_RUN, 32'h0, 1'b0);
    add_step("led_wait_3ticks", OP_WAIT, 0, 32'd66);
    add_step("led_run_off", OP_CHK, SIG_LED_RUN, 32'h0, 1'b1);
    add_step("led_good_off", OP_CHK, SIG_LED_GOOD, 32'h0, 1'b1);
    // Command ptt, inhibit and PA config
    add_step("run_high", OP_PIN, PIN_RUN, 32'h1);
    add_step("cmd_ptt_on", OP_WR, 'h4, 32'h0000_00c0, 1'b0);
    add_step("tx_on_ptt", OP_CHK, SIG_TX_ON, 32'h0, 1'b1);
    add_step("led_tx_on", OP_CHK, SIG_LED_TX, 32'h0, 1'b0);
    add_step("inhibit_low", OP_PIN, PIN_INHIBIT_N, 32'h0);
    add_step("tx_inhibited", OP_CHK, SIG_TX_ON, 32'h0, 1'b0);
    add_step("inhibit_high", OP_PIN, PIN_INHIBIT_N, 32'h1);
    add_step("tx_resumed", OP_CHK, SIG_TX_ON, 32'h0, 1'b1);
    add_step("resp_slot2_tx", OP_RESP, 0, 32'h0, 1'b0,
             expect_tlm(2'd2, slot_payload(2'd2, 1'b0)));
    add_step("resp_echo_tx_on", OP_RESP, 0, 32'h0, 1'b0,
             expect_echo(6'h00, 1'b1, 32'h1234_5678));
    add_step("cfg_pa_data", OP_WR, 'h0, 32'h0008_0000, 1'b0);
    add_step("cfg_pa_issue", OP_WR, 'h4, 32'h0000_0089, 1'b0);
    add_step("cfg_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b1);
    add_step("cfg_pa_en", OP_CHK, SIG_PA_EN, 32'h0, 1'b1);
    add_step("cfg_pa_envpa", OP_CHK, SIG_ENVPA, 32'h0, 1'b1);
    add_step("cfg_pa_rfsw", OP_CHK, SIG_RFSW, 32'h0, 1'b1);
    add_step("cfg_vna_data", OP_WR, 'h0, 32'h0088_0000, 1'b0);
    add_step("cfg_vna_issue", OP_WR, 'h4, 32'h0000_0089, 1'b0);
    add_step("vna_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b0);
    add_step("vna_pa_en", OP_CHK, SIG_PA_EN, 32'h0, 1'b0);
    add_step("vna_envpa", OP_CHK, SIG_ENVPA, 32'h0, 1'b1);
    add_step("vna_rfsw", OP_CHK, SIG_RFSW, 32'h0, 1'b0);
    add_step("cfg_trdis_data", OP_WR, 'h0, 32'h0004_0000, 1'b0);
    add_step("cfg_trdis_issue", OP_WR, 'h4, 32'h0000_0089, 1'b0);
    add_step("trdis_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b0);
    add_step("trdis_pa_en", OP_CHK, SIG_PA_EN, 32'h0, 1'b0);
    add_step("trdis_rfsw", OP_CHK, SIG_RFSW, 32'h0, 1'b0);
    // T/R relay stays in use while the PA itself is off
    add_step("cfg_open_data", OP_WR, 'h0, 32'h0000_0000, 1'b0);
    add_step("cfg_open_issue", OP_WR, 'h4, 32'h0000_0089, 1'b0);
    add_step("open_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b1);
    add_step("open_pa_en", OP_CHK, SIG_PA_EN, 32'h0, 1'b0);
    add_step("cfg_rx_data", OP_WR, 'h0, 32'h0008_0000, 1'b0);
    add_step("cfg_rx_issue", OP_WR, 'h4, 32'h0000_0009, 1'b0);
    add_step("ptt_off_tx_on", OP_CHK, SIG_TX_ON, 32'h0, 1'b0);
    add_step("ptt_off_envpa", OP_CHK, SIG_ENVPA, 32'h0, 1'b0);
    add_step("ptt_off_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b0);
    add_step("ptt_off_rfsw", OP_CHK, SIG_RFSW, 32'h0, 1'b1);
    // CW key with a 5 ms hang from {0x01, 2'b01}
    add_step("hang_data", OP_WR, 'h0, 32'h0101_0000, 1'b0);
    add_step("hang_issue", OP_WR, 'h4, 32'h0000_0010, 1'b0);
    add_step("key_down", OP_PIN, PIN_KEY_N, 32'h0);
    add_step("key_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b1);
    add_step("key_envpa", OP_CHK, SIG_ENVPA, 32'h0, 1'b1);
    add_step("key_tx_early", OP_CHK, SIG_TX_ON, 32'h0, 1'b0);
    add_step("key_wait_15ms", OP_WAIT, 0, 32'd15);
    add_step("key_tx_15ms", OP_CHK, SIG_TX_ON, 32'h0, 1'b0);
    add_step("key_wait_17ms", OP_WAIT, 0, 32'd2);
    add_step("key_tx_17ms", OP_CHK, SIG_TX_ON, 32'h0, 1'b1);
    add_step("key_up", OP_PIN, PIN_KEY_N, 32'h1);
    add_step("hang_start", OP_CHK, SIG_ENVPA, 32'h0, 1'b1);
    add_step("hang_wait_45ms", OP_WAIT, 0, 32'd45);
    add_step("key_up_tx_off", OP_CHK, SIG_TX_ON, 32'h0, 1'b0);
    add_step("hang_45ms", OP_CHK, SIG_ENVPA, 32'h0, 1'b1);
    add_step("hang_wait_47ms", OP_WAIT, 0, 32'd2);
    add_step("hang_done", OP_CHK, SIG_ENVPA, 32'h0, 1'b0);
    add_step("hang_done_pa_tr", OP_CHK, SIG_PA_TR, 32'h0, 1'b0);
  endtask

  initial begin : main
    logic [31:0] lo;
    logic [31:0] hi;
    logic        err;
    logic        rdy;
    resp_word_u  got;

    void'($urandom(76));
    fwd_pwr      = 12'($urandom);
    rev_pwr      = 12'($urandom);
    temperature  = 12'($urandom);
    bias_current = 12'($urandom);
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = 4'h0;
    pwdata       = 32'h0;
    run          = 1'b0;
    rx_clip      = 1'b0;
    rx_good_lvl  = 1'b0;
    cw_key_n     = 1'b1;   // Keys idle high
    ptt_n        = 1'b1;
    tx_inhibit_n = 1'b1;

    build_table();
    cycle_limit = 1000 + 20 * n_steps;
    for (int i = 0; i < n_steps; i++) begin
      if (step_op[i] == OP_WAIT)
        cycle_limit = cycle_limit + step_data[i] * MS_CYCLES;
    end

    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < n_steps; i++) begin
      case (step_op[i])
        OP_WR: begin
          apb_access(1'b1, step_sel[i][3:0], step_data[i], lo, err, rdy);
          check_output(step_name[i], 1'b1, rdy);
          check_slverr(step_name[i], step_bit[i], err);
        end
        OP_RD: begin
          apb_access(1'b0, step_sel[i][3:0], 32'h0, lo, err, rdy);
          check_output(step_name[i], 1'b1, rdy);
          check_slverr(step_name[i], step_bit[i], err);
        end
        OP_RESP: begin
          apb_access(1'b0, REG_RESP_LO, 32'h0, lo, err, rdy);
          check_slverr(step_name[i], 1'b0, err);
          apb_access(1'b0, REG_RESP_HI, 32'h0, hi, err, rdy);   // Also requests the next word
          check_slverr(step_name[i], 1'b0, err);
          got = {hi[7:0], lo};
          compare_resp(step_name[i], step_word[i], got);
        end
        OP_PIN: begin
          @(negedge clk);
          set_pin(step_sel[i], step_data[i][0]);
        end
        OP_PULSE: begin
          @(negedge clk);
          set_pin(step_sel[i], 1'b1);
          @(negedge clk);
          set_pin(step_sel[i], 1'b0);
        end
        OP_WAIT: repeat (step_data[i] * MS_CYCLES) @(negedge clk);
        default: begin
          repeat (3) @(negedge clk);   // Covers the 2-flop synchronizer
          check_output(step_name[i], step_bit[i], pick_output(step_sel[i]));
        end
      endcase
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire
